//--- src/cavlc_config.svh
`ifndef CAVLC_CONFIG_SVH
`define CAVLC_CONFIG_SVH

// Coefficients per 4x4 block
`define BLOCK_COEFFS 16

// Signed coefficient width
`define COEFF_W 8

// Bit-string buffer, worst case 3 sign bits plus 16 escape codewords of 28 bits
`define CODE_W 512

`define LEN_W 10 // Holds a bit count up to CODE_W

`endif

//--- src/cavlcPkg.sv
`include "cavlc_config.svh"

package cavlcPkg;

    typedef logic signed [`COEFF_W-1:0] coeff_t;

    // Zigzag scan order, entry 0 is the DC position
    typedef coeff_t [`BLOCK_COEFFS-1:0] coeffBlock_t;

    typedef struct packed {
        logic [4:0]                 totalCoeff;
        logic [1:0]                 trailingOnes;
        logic [2:0]                 t1Signs;      // Bit 0 is the first one found, 1 means negative
        logic [4:0]                 levelCnt;     // Nonzero levels other than trailing ones
        coeff_t [`BLOCK_COEFFS-1:0] levels;       // Highest frequency at index 0
    } blockInfo_t;

    // First emitted bit sits at position len-1
    typedef struct packed {
        logic [`CODE_W-1:0] bits;
        logic [`LEN_W-1:0]  len;
    } levelBits_t;

endpackage

//--- src/blockAnalyzer.sv
`include "cavlc_config.svh"

module blockAnalyzer import cavlcPkg::*; (
    input  logic        clk,
    input  logic        enc_rst,
    input  logic        capture,
    input  coeffBlock_t inBlock,
    output blockInfo_t  info
);

    blockInfo_t scan;
    coeff_t     coeff;
    logic       t1Closed;

    // Reverse scan from the highest frequency down to DC
    always_comb begin
        scan     = '0;
        coeff    = '0;
        t1Closed = 1'b0;
        for (int i = `BLOCK_COEFFS - 1; i >= 0; i--) begin
            coeff = inBlock[i];
            if (coeff != '0) begin
                if (!t1Closed && scan.trailingOnes != 2'd3 && (coeff == 1 || coeff == -1)) begin
                    scan.t1Signs[scan.trailingOnes] = coeff[`COEFF_W-1];
                    scan.trailingOnes = scan.trailingOnes + 2'd1;
                end else begin
                    // Any other value ends the trailing-ones run
                    t1Closed = 1'b1;
                    scan.levels[scan.levelCnt[3:0]] = coeff;
                    scan.levelCnt = scan.levelCnt + 5'd1;
                end
                scan.totalCoeff = scan.totalCoeff + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            info <= '0;
        end else if (capture) begin
            info <= scan;
        end
    end

    t1WithinTotal: assert property (@(posedge clk) disable iff (enc_rst)
        {3'd0, info.trailingOnes} <= info.totalCoeff);

endmodule

//--- src/levelCodeEncoder.sv
`include "cavlc_config.svh"

module levelCodeEncoder import cavlcPkg::*; (
    input  logic       clk,
    input  logic       enc_rst,
    input  logic       blockClear,
    input  logic       load,
    input  logic       step,
    input  blockInfo_t info,
    output logic       done,
    output levelBits_t result
);

    localparam int LenW = `LEN_W;

    logic [4:0]         idx;
    logic [2:0]         suffixLen;
    logic [2:0]         nextSuffixLen;
    logic [`CODE_W-1:0] codeBuf;
    logic [`CODE_W-1:0] signBits;
    logic [LenW-1:0]    codeLen;
    coeff_t             level;
    logic [`COEFF_W:0]  levelAbs;
    logic [11:0]        levelCode;
    logic [11:0]        scaled;
    logic [11:0]        lowMask;
    logic [3:0]         prefix;
    logic [11:0]        suffix;
    logic [3:0]         suffixW;
    logic [12:0]        codeword;
    logic [4:0]         cwLen;

    assign done = (idx == info.levelCnt);

    assign level    = info.levels[idx[3:0]];
    assign levelAbs = level[`COEFF_W-1] ? (9'd0 - {level[`COEFF_W-1], level}) : {1'b0, level};

    // Trailing-ones signs, first found is emitted first
    always_comb begin
        signBits = '0;
        for (int i = 0; i < 3; i++) begin
            if (i < info.trailingOnes) begin
                signBits = {signBits[`CODE_W-2:0], info.t1Signs[i]};
            end
        end
    end

    always_comb begin
        levelCode = 12'({levelAbs, 1'b0}) - (level[`COEFF_W-1] ? 12'd1 : 12'd2);
        if (idx == 5'd0 && info.trailingOnes != 2'd3) begin
            levelCode = levelCode - 12'd2; // First level cannot be +-1 here
        end
        scaled  = levelCode >> suffixLen;
        lowMask = ~(12'hfff << suffixLen);

        if (scaled < 12'd14) begin
            prefix  = scaled[3:0];
            suffix  = levelCode & lowMask;
            suffixW = {1'b0, suffixLen};
        end else if (suffixLen == 3'd0 && levelCode < 12'd30) begin
            prefix  = 4'd14;
            suffix  = levelCode - 12'd14; // 4-bit suffix
            suffixW = 4'd4;
        end else if (suffixLen != 3'd0 && scaled == 12'd14) begin
            prefix  = 4'd14;
            suffix  = levelCode & lowMask;
            suffixW = {1'b0, suffixLen};
        end else begin
            // Escape
            prefix  = 4'd15;
            suffix  = levelCode - (12'd15 << suffixLen) - (suffixLen == 3'd0 ? 12'd15 : 12'd0);
            suffixW = 4'd12;
        end

        // Zeros, a one, then the suffix
        codeword = (13'd1 << suffixW) | {1'b0, suffix};
        cwLen    = 5'(prefix) + 5'd1 + 5'(suffixW);
    end

    // Adaptive suffixLength after the current level
    always_comb begin
        nextSuffixLen = (suffixLen == 3'd0) ? 3'd1 : suffixLen;
        if (levelAbs > (9'd3 << (nextSuffixLen - 3'd1)) && nextSuffixLen != 3'd6) begin
            nextSuffixLen = nextSuffixLen + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst || blockClear) begin
            idx       <= '0;
            suffixLen <= '0;
            codeLen   <= '0;
        end else if (load) begin
            idx       <= '0;
            suffixLen <= (info.totalCoeff > 5'd10 && info.trailingOnes != 2'd3) ? 3'd1 : 3'd0;
            codeLen   <= LenW'(info.trailingOnes);
        end else if (step && !done) begin
            idx       <= idx + 5'd1;
            suffixLen <= nextSuffixLen;
            codeLen   <= codeLen + LenW'(cwLen);
        end
    end

    always_ff @(posedge clk) begin
        if (blockClear) begin
            codeBuf <= '0;
        end else if (load) begin
            codeBuf <= signBits;
        end else if (step && !done) begin
            codeBuf <= (codeBuf << cwLen) | codeword;
        end
    end

    assign result.bits = codeBuf;
    assign result.len  = codeLen;

    // The sequencer stops stepping once the level list is used up
    noStepWhenDone: assert property (@(posedge clk) disable iff (enc_rst)
        step |-> !done);

endmodule

//--- src/levelSequencer.sv
module levelSequencer (
    input  logic clk,
    input  logic enc_rst,
    input  logic inValid,
    output logic inReady,
    output logic capture,
    output logic load,
    output logic step,
    output logic blockClear,
    input  logic done,
    output logic outValid,
    input  logic outReady
);

    typedef enum logic [2:0] {
        sIdle,
        sLoad,
        sCode,
        sPresent,
        sClear
    } seqState_t;

    seqState_t state;
    seqState_t nextState;

    assign capture    = inValid && inReady;
    assign load       = (state == sLoad);
    assign step       = (state == sCode) && !done; // One level per cycle
    assign outValid   = (state == sPresent);
    assign blockClear = (state == sClear);

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (capture) begin
                    nextState = sLoad;
                end
            end
            sLoad: begin
                nextState = sCode;
            end
            sCode: begin
                if (done) begin
                    nextState = sPresent;
                end
            end
            sPresent: begin
                if (outReady) begin
                    nextState = sClear; // Held under back-pressure
                end
            end
            sClear: begin
                nextState = sIdle;
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    // inReady follows the idle state one edge late out of reset
    always_ff @(posedge clk) begin
        if (enc_rst) begin
            state   <= sIdle;
            inReady <= 1'b0;
        end else begin
            state   <= nextState;
            inReady <= (nextState == sIdle);
        end
    end

    outValidHeld: assert property (@(posedge clk) disable iff (enc_rst)
        outValid && !outReady |=> outValid);

endmodule

//--- src/cavlcLevelTop.sv
module cavlcLevelTop import cavlcPkg::*; (
    input  logic        clk,
    input  logic        enc_rst,
    input  logic        inValid,
    output logic        inReady,
    input  coeffBlock_t inBlock,
    output logic        outValid,
    input  logic        outReady,
    output levelBits_t  outBits
);

    logic       capture;
    logic       load;
    logic       step;
    logic       blockClear;
    logic       done;
    blockInfo_t info;

    blockAnalyzer analyzer_i (
        .clk     (clk),
        .enc_rst (enc_rst),
        .capture (capture),
        .inBlock (inBlock),
        .info    (info)
    );

    levelCodeEncoder encoder_i (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .blockClear (blockClear),
        .load       (load),
        .step       (step),
        .info       (info),
        .done       (done),
        .result     (outBits)
    );

    levelSequencer sequencer_i (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .inValid    (inValid),
        .inReady    (inReady),
        .capture    (capture),
        .load       (load),
        .step       (step),
        .blockClear (blockClear),
        .done       (done),
        .outValid   (outValid),
        .outReady   (outReady)
    );

endmodule

//--- test/tbClock.sv
module tbClock (
    output logic clk,
    output logic enc_rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset held over the first 4 rising edges
    initial begin
        enc_rst = 1'b1;
        repeat (4) @(posedge clk);
        enc_rst <= 1'b0;
    end

endmodule

//--- test/cavlcChecker.sv
`include "cavlc_config.svh"

module cavlcChecker import cavlcPkg::*; (
    input  logic        clk,
    input  logic        enc_rst,
    input  logic        inValid,
    input  logic        inReady,
    input  coeffBlock_t inBlock,
    input  logic        outValid,
    input  logic        outReady,
    input  levelBits_t  outBits,
    input  logic        runDone,
    output int          checked,
    output int          errors,
    output logic        reportDone
);

    localparam int LenW = `LEN_W;

    coeffBlock_t pending[$];
    levelBits_t  heldBits;
    logic        stalled;
    int          checkCount;
    int          valueErrors;
    int          otherErrors;

    // Expected level bits of one block with the first emitted bit at position len-1
    function automatic levelBits_t expectBits(input coeffBlock_t blk);
        int         levels[$];
        bit         stream[$];
        int         total;
        int         t1Count;
        bit         t1Open;
        int         v;
        int         mag;
        int         code;
        int         sl;
        int         pfx;
        int         sfxW;
        int         sfx;
        levelBits_t expected;
        total   = 0;
        t1Count = 0;
        t1Open  = 1'b1;
        for (int i = `BLOCK_COEFFS - 1; i >= 0; i--) begin
            v = int'($signed(blk[i]));
            if (v != 0) begin
                total = total + 1;
                if (t1Open && t1Count < 3 && (v == 1 || v == -1)) begin
                    stream.push_back(v < 0); // Sign bit is 1 for negative
                    t1Count = t1Count + 1;
                end else begin
                    t1Open = 1'b0;
                    levels.push_back(v);
                end
            end
        end
        sl = (total > 10 && t1Count < 3) ? 1 : 0;
        for (int k = 0; k < levels.size(); k++) begin
            v    = levels[k];
            mag  = (v < 0) ? -v : v;
            code = (v > 0) ? 2 * v - 2 : -2 * v - 1;
            if (k == 0 && t1Count < 3) begin
                code = code - 2;
            end
            if (sl == 0 && code < 14) begin
                pfx  = code;
                sfxW = 0;
                sfx  = 0;
            end else if (sl == 0 && code < 30) begin
                pfx  = 14;
                sfxW = 4;
                sfx  = code - 14;
            end else if (sl > 0 && (code >> sl) < 15) begin
                pfx  = code >> sl; // Prefix 14 falls in here as well
                sfxW = sl;
                sfx  = code & ((1 << sl) - 1);
            end else begin
                pfx  = 15;
                sfxW = 12;
                sfx  = (sl == 0) ? code - 30 : code - (15 << sl);
            end
            for (int p = 0; p < pfx; p++) begin
                stream.push_back(1'b0);
            end
            stream.push_back(1'b1);
            for (int b = sfxW - 1; b >= 0; b--) begin
                stream.push_back(bit'((sfx >> b) & 1));
            end
            if (sl == 0) begin
                sl = 1;
            end
            if (mag > (3 << (sl - 1)) && sl < 6) begin
                sl = sl + 1;
            end
        end
        expected     = '0;
        expected.len = LenW'(stream.size());
        for (int b = 0; b < stream.size(); b++) begin
            expected.bits[stream.size() - 1 - b] = stream[b];
        end
        return expected;
    endfunction

    always @(posedge clk) begin
        levelBits_t want;
        if (enc_rst) begin
            pending.delete();
            stalled     = 1'b0;
            checkCount  = 0;
            valueErrors = 0;
            otherErrors = 0;
            checked    <= 0;
            errors     <= 0;
            reportDone <= 1'b0;
        end else begin
            if (inReady && pending.size() != 0) begin
                $display("inReady was high while a block was still in flight");
                otherErrors++;
            end
            if (inValid && inReady) begin
                pending.push_back(inBlock);
            end
            if (stalled) begin
                if (!outValid) begin
                    $display("outValid dropped while the output was held back");
                    otherErrors++;
                end else if (outBits !== heldBits) begin
                    $display("CHECK FAILED outBits (held): got %h expected %h",
                        outBits, heldBits);
                    valueErrors++;
                end
            end
            if (outValid && outReady) begin
                if (pending.size() == 0) begin
                    $display("an output block arrived with no accepted block pending");
                    otherErrors++;
                end else begin
                    want = expectBits(pending.pop_front());
                    checkCount++;
                    if (outBits.len !== want.len) begin
                        $display("CHECK FAILED outBits.len: got %h expected %h",
                            outBits.len, want.len);
                        valueErrors++;
                    end
                    if (outBits.bits !== want.bits) begin
                        $display("CHECK FAILED outBits.bits: got %h expected %h",
                            outBits.bits, want.bits);
                        valueErrors++;
                    end
                end
            end
            stalled  = outValid && !outReady;
            heldBits = outBits;
            if (runDone && !reportDone) begin
                if (pending.size() != 0) begin
                    $display("%0d accepted blocks never came out", pending.size());
                    otherErrors++;
                end
                $display("checks %0d, value errors %0d, other errors %0d",
                    checkCount, valueErrors, otherErrors);
                reportDone <= 1'b1;
            end
            checked <= checkCount;
            errors  <= valueErrors + otherErrors;
        end
    end

endmodule

//--- test/cavlcTb.sv
`include "cavlc_config.svh"

module cavlcTb import cavlcPkg::*; ();

    localparam int DirectedCount = 13;
    localparam int StallCount    = 40;
    localparam int RandomCount   = 300;
    localparam int TotalBlocks   = DirectedCount + StallCount + RandomCount;
    localparam int TimeoutCycles = 40 * TotalBlocks + 200;

    logic        clk;
    logic        enc_rst;
    logic        inValid;
    logic        inReady;
    coeffBlock_t inBlock;
    logic        outValid;
    logic        outReady = 1'b0;
    levelBits_t  outBits;
    logic        stallMode = 1'b0;
    logic        runDone = 1'b0;
    logic        reportDone;
    int          seed;
    int          sent = 0;
    int          cycles = 0;
    int          stretch = 0;
    int          checked;
    int          errors;

    tbClock clock_i (
        .clk     (clk),
        .enc_rst (enc_rst)
    );

    cavlcLevelTop dut_i (
        .clk      (clk),
        .enc_rst  (enc_rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inBlock  (inBlock),
        .outValid (outValid),
        .outReady (outReady),
        .outBits  (outBits)
    );

    cavlcChecker monitor_i (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .inValid    (inValid),
        .inReady    (inReady),
        .inBlock    (inBlock),
        .outValid   (outValid),
        .outReady   (outReady),
        .outBits    (outBits),
        .runDone    (runDone),
        .checked    (checked),
        .errors     (errors),
        .reportDone (reportDone)
    );

    // Called on a rising edge and returns on the accepting edge
    task automatic sendBlock(input coeffBlock_t blk);
        inValid <= 1'b1;
        inBlock <= blk;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        inValid <= 1'b0;
        sent = sent + 1;
    endtask

    task automatic makeRandomBlock(output coeffBlock_t blk);
        int zeroCut;
        int pick;
        int mag;
        zeroCut = $unsigned($random(seed)) % 10; // Density varies per block
        for (int i = 0; i < `BLOCK_COEFFS; i++) begin
            pick = $unsigned($random(seed)) % 10;
            if (pick < zeroCut) begin
                mag = 0;
            end else if (pick < 7) begin
                mag = 1;
            end else if (pick < 9) begin
                mag = 2 + $unsigned($random(seed)) % 8;
            end else begin
                mag = 1 + $unsigned($random(seed)) % 127; // levelCode stays within 8 bits
            end
            blk[i] = coeff_t'(($random(seed) & 1) ? -mag : mag);
        end
    endtask

    // Output back-pressure in random stretches
    always @(posedge clk) begin
        if (!stallMode) begin
            outReady <= 1'b1;
        end else if (stretch == 0) begin
            outReady <= ($unsigned($random(seed)) % 3) == 0;
            stretch  <= $unsigned($random(seed)) % 8;
        end else begin
            stretch <= stretch - 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("timeout after %0d cycles with %0d of %0d blocks checked",
                cycles, checked, sent);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        coeffBlock_t blk;
        seed    = 32'h4a4a_855b;
        inValid = 1'b0;
        inBlock = '0;
        @(posedge clk);
        while (enc_rst) begin
            @(posedge clk);
        end

        blk = '0; // All zero
        sendBlock(blk);
        blk = '0;
        blk[9] = 8'sd1;
        blk[4] = -8'sd1;
        blk[0] = -8'sd1;
        sendBlock(blk);
        blk = '0;
        blk[15] = -8'sd1;
        sendBlock(blk);

        blk = '0; // Three trailing ones before prefix 14 at suffixLength 0
        blk[15] = 8'sd1;
        blk[14] = -8'sd1;
        blk[13] = 8'sd1;
        blk[10] = 8'sd8;
        sendBlock(blk);
        blk = '0;
        blk[12] = -8'sd1;
        blk[9] = 8'sd5;
        blk[4] = 8'sd2;
        blk[0] = -8'sd2;
        sendBlock(blk);
        blk = '0;
        blk[7] = 8'sd9;
        blk[6] = 8'sd1;
        sendBlock(blk);
        blk = '0;
        blk[2] = -8'sd3;
        blk[1] = 8'sd1;
        blk[0] = -8'sd1;
        sendBlock(blk);
        blk = '0; // Prefix 14 with a 1-bit suffix
        blk[2] = 8'sd2;
        blk[1] = 8'sd15;
        sendBlock(blk);
        blk = '0; // Escape at suffixLength 0
        blk[0] = 8'sd50;
        sendBlock(blk);

        blk = '0;
        for (int i = 0; i < 12; i++) begin
            blk[i] = coeff_t'((i % 2 == 1) ? -(9 * i + 4) : (9 * i + 4));
        end
        sendBlock(blk);
        for (int i = 0; i < `BLOCK_COEFFS; i++) begin
            blk[i] = coeff_t'((i % 2 == 1) ? -100 : 100); // suffixLength tops out at 6
        end
        sendBlock(blk);
        for (int i = 0; i < 13; i++) begin
            blk[i] = coeff_t'(2 + i % 2);
        end
        blk[13] = 8'sd1;
        blk[14] = -8'sd1;
        blk[15] = 8'sd1;
        sendBlock(blk);
        blk = '0;
        for (int i = 0; i < 11; i++) begin
            blk[i] = -8'sd2;
        end
        sendBlock(blk);

        stallMode <= 1'b1;
        for (int n = 0; n < StallCount; n++) begin
            makeRandomBlock(blk);
            sendBlock(blk);
        end
        stallMode <= 1'b0;
        for (int n = 0; n < RandomCount; n++) begin
            makeRandomBlock(blk);
            repeat ($unsigned($random(seed)) % 3) @(posedge clk);
            sendBlock(blk);
        end

        // Last block drains once the DUT is back in idle
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        runDone <= 1'b1;
        @(posedge clk);
        while (!reportDone) begin
            @(posedge clk);
        end
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+src
src/cavlcPkg.sv
src/blockAnalyzer.sv
src/levelCodeEncoder.sv
src/levelSequencer.sv
src/cavlcLevelTop.sv
test/tbClock.sv
test/cavlcChecker.sv
test/cavlcTb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cavlcTb -Mdir obj_dir -o cavlcSim

# The log decides the result, so a failing run still reaches the search below
./obj_dir/cavlcSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
